//--- filelist.f
+incdir+include
hdl/trace_pkg.sv
hdl/pipeline_tag_tracker.sv
hdl/stage_record_bank.sv
hdl/retire_reporter.sv
hdl/pipeline_trace_unit.sv
verification/trace_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the trace unit testbench with Verilator, runs it and checks the log

set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
SIM_BIN=trace_tb_sim
LOG_FILE=sim.log

# Compile and elaborate, assertions enabled
verilator --binary --timing --assert -j 0 \
    --timescale 1ns/100ps \
    -f filelist.f \
    --top-module trace_tb \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"

# Run, keeping a copy of the output
"./$BUILD_DIR/$SIM_BIN" 2>&1 | tee "$LOG_FILE"

# The testbench prints the fail message on any failed check or timeout
if grep -q "Some tests failed" "$LOG_FILE"; then
    echo "Simulation reported failures, see $LOG_FILE"
    exit 1
fi

echo "Simulation finished without reported failures"
exit 0

//--- include/trace_ref_model.svh
`ifndef TRACE_REF_MODEL_SVH
`define TRACE_REF_MODEL_SVH

//////////////////////////////
// Expected retirement record
//////////////////////////////
typedef struct packed {
    tag_t                         tag;
    event_code_t [NUM_STAGES-1:0] evt;      // Fetch code in element 0
    hold_cnt_t   [NUM_STAGES-1:0] hold;     // Same order as the codes
    cycle_t                       cycle;    // Number of the write-back cycle
} exp_record_t;

// Model pipeline, holds the state of the current cycle
logic        [NUM_STAGES-1:0] m_valid;
tag_t        [NUM_STAGES-1:0] m_tag;
logic        [NUM_STAGES-1:0] m_prev_valid;     // Occupancy one cycle back
tag_t        [NUM_STAGES-1:0] m_prev_tag;
event_code_t                  m_evt  [NUM_STAGES][TAG_DEPTH];
hold_cnt_t                    m_hold [NUM_STAGES][TAG_DEPTH];
cycle_t                       m_cycle;
exp_record_t                  exp_q [$];        // Records the DUT still owes

// Right after reset only fetch is live, with tag 0
function automatic void model_reset();
    m_valid            = '0;
    m_valid[STG_FETCH] = 1'b1;
    m_tag              = '0;
    m_prev_valid       = '0;
    m_prev_tag         = '0;
    m_cycle            = '0;
endfunction

// One clock cycle, with the stall level and the codes present during it
function automatic void model_step(input logic stall_in,
                                   input event_code_t [NUM_STAGES-1:0] evt_in);
    tag_t        t;
    hold_cnt_t   h;
    exp_record_t rec;

    // Every live stage records its code and hold count
    for (int s = 0; s < NUM_STAGES; s++) begin
        if (m_valid[s]) begin
            t = m_tag[s];
            if (!m_prev_valid[s] || (m_prev_tag[s] != t)) begin
                h = hold_cnt_t'(1);                        // Just arrived
            end else if (m_hold[s][t] >= hold_cnt_t'(HOLD_MAX)) begin
                h = hold_cnt_t'(HOLD_MAX);                 // Stuck at the cap
            end else begin
                h = m_hold[s][t] + hold_cnt_t'(1);         // Held one more cycle
            end
            m_evt[s][t]  = evt_in[s];                      // Latest code wins
            m_hold[s][t] = h;
        end
    end

    // A live write-back stage retires at the end of this cycle
    if (m_valid[STG_WB]) begin
        rec.tag = m_tag[STG_WB];
        for (int s = 0; s < NUM_STAGES; s++) begin
            rec.evt[s]  = m_evt[s][rec.tag];
            rec.hold[s] = m_hold[s][rec.tag];
        end
        rec.cycle = m_cycle;
        exp_q.push_back(rec);
    end

    m_prev_valid = m_valid;
    m_prev_tag   = m_tag;

    // Back half always drains, moved first so it copies old values
    m_valid[STG_WB]     = m_valid[STG_MEMORY];
    m_tag[STG_WB]       = m_tag[STG_MEMORY];
    m_valid[STG_MEMORY] = m_valid[STG_EXECUTE];
    m_tag[STG_MEMORY]   = m_tag[STG_EXECUTE];

    if (stall_in) begin
        m_valid[STG_EXECUTE] = 1'b0;                       // Bubble, front two hold
    end else begin
        m_valid[STG_EXECUTE] = m_valid[STG_DECODE];
        m_tag[STG_EXECUTE]   = m_tag[STG_DECODE];
        m_valid[STG_DECODE]  = m_valid[STG_FETCH];
        m_tag[STG_DECODE]    = m_tag[STG_FETCH];
        m_tag[STG_FETCH]     = m_tag[STG_FETCH] + tag_t'(1);  // Next tag, wraps at 16
    end

    m_cycle = m_cycle + cycle_t'(1);
endfunction

`endif

//--- verification/trace_tb.sv
`timescale 1ns/100ps

module trace_tb import trace_pkg::*; ();

    `include "trace_ref_model.svh"

    //////////////////////////////
    // Run length
    //////////////////////////////
    localparam int RST_CYCLES    = 8;
    localparam int PLAIN_CYCLES  = 100;     // No stall at all
    localparam int SINGLE_ROUNDS = 5;       // One stall cycle then nine free ones
    localparam int LONG_STALL    = 10;      // Long enough to reach the hold cap
    localparam int LONG_TAIL     = 30;
    localparam int RAND_CYCLES   = 1000;
    localparam int DRAIN_CYCLES  = 8;       // Stall held until write-back is empty
    localparam int TOTAL_CYCLES  = RST_CYCLES + PLAIN_CYCLES + SINGLE_ROUNDS * 10
                                 + LONG_STALL + LONG_TAIL + RAND_CYCLES + DRAIN_CYCLES;
    localparam int RUN_LIMIT     = TOTAL_CYCLES + TOTAL_CYCLES / 4;   // About 1500

    logic                         clk;
    logic                         rst_n;
    logic                         stall;
    event_code_t [NUM_STAGES-1:0] stage_evt;
    logic                         done;
    tag_t                         done_tag;
    event_code_t [NUM_STAGES-1:0] done_evt;
    hold_cnt_t   [NUM_STAGES-1:0] done_hold;
    cycle_t                       done_cycle;

    logic stim_done;                        // Stimulus over and back half drained
    int   cyc_cnt   = 0;
    int   rec_cnt   = 0;                    // Records compared
    int   sat_cnt   = 0;                    // Records with fetch hold at the cap
    int   err_value = 0;
    int   err_other = 0;

    pipeline_trace_unit dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .stage_evt  (stage_evt),
        .done       (done),
        .done_tag   (done_tag),
        .done_evt   (done_evt),
        .done_hold  (done_hold),
        .done_cycle (done_cycle)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;                  // 100 ns period

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    // Drives one cycle's stall level and fresh random codes
    task automatic apply_cycle(input logic st);
        stall <= st;
        for (int s = 0; s < NUM_STAGES; s++) begin
            stage_evt[s] <= event_code_t'($urandom);
        end
        @(posedge clk);
    endtask

    initial begin
        void'($urandom(32'hed3e_5a77));
        rst_n     = 1'b0;
        stall     = 1'b0;
        stage_evt = '0;
        stim_done = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        repeat (PLAIN_CYCLES) apply_cycle(1'b0);      // One retirement per cycle
        repeat (SINGLE_ROUNDS) begin
            apply_cycle(1'b1);                        // Lone stall gives one gap
            repeat (9) apply_cycle(1'b0);
        end
        repeat (LONG_STALL) apply_cycle(1'b1);        // Front saturates while back drains
        repeat (LONG_TAIL) apply_cycle(1'b0);
        repeat (RAND_CYCLES) apply_cycle(($urandom % 32'd4) == 32'd0);  // About 25 %
        repeat (DRAIN_CYCLES) apply_cycle(1'b1);
        stim_done <= 1'b1;
    end

    //////////////////////////////
    // Checking
    //////////////////////////////

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        assert (got == want) else begin
            $display("** Error: %s = %0h, expected %0h", name, got, want);
            err_value++;
        end
    endtask

    // One done pulse against the oldest expected record
    task automatic check_record();
        exp_record_t want;
        assert (exp_q.size() != 0) else begin
            $display("Error: done pulsed at %0t with no instruction due to retire", $time);
            err_other++;
        end
        if (exp_q.size() != 0) begin
            want = exp_q.pop_front();
            rec_cnt++;
            if (rec_cnt == 1) begin
                // First instruction leaves write-back in cycle 4
                check_value("done_tag", 64'(done_tag), 64'(0));
                check_value("done_cycle", 64'(done_cycle), 64'(4));
            end
            check_value("done_tag", 64'(done_tag), 64'(want.tag));
            for (int s = 0; s < NUM_STAGES; s++) begin
                check_value($sformatf("done_evt[%0d]", s), 64'(done_evt[s]), 64'(want.evt[s]));
                check_value($sformatf("done_hold[%0d]", s), 64'(done_hold[s]),
                            64'(want.hold[s]));
            end
            check_value("done_cycle", 64'(done_cycle), 64'(want.cycle));
            if (done_hold[STG_FETCH] == hold_cnt_t'(HOLD_MAX)) begin
                sat_cnt++;
            end
        end
    endtask

    task automatic print_summary();
        $display("Summary: %0d records checked, %0d value errors, %0d other errors",
                 rec_cnt, err_value, err_other);
    endtask

    // Pops the record due now and then steps the model over the cycle that ends here
    always @(posedge clk) begin
        if (!rst_n) begin
            model_reset();
        end else begin
            if (done) begin
                check_record();
            end
            if (stim_done) begin
                assert (exp_q.size() == 0) else begin
                    $display("Error: %0d expected records never came out", exp_q.size());
                    err_other++;
                end
                assert (sat_cnt > 0) else begin
                    $display("Error: no record showed a fetch hold count at the cap");
                    err_other++;
                end
                print_summary();
                if ((err_value + err_other) == 0) begin
                    $display("All tests passed");
                end else begin
                    $display("Some tests failed");
                end
                $finish;
            end else begin
                model_step(stall, stage_evt);
            end
        end
    end

    // Ends a run that never reaches its end of stimulus
    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= RUN_LIMIT) begin
            $display("Error: run did not finish within %0d cycles", RUN_LIMIT);
            print_summary();
            $display("Some tests failed");
            $finish;
        end
    end

endmodule

//--- hdl/pipeline_trace_unit.sv
`timescale 1ns/100ps

module pipeline_trace_unit import trace_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          stall,       // Pipeline stall level
    input  event_code_t [NUM_STAGES-1:0]  stage_evt,   // One code per stage, every cycle
    output logic                          done,        // Retirement pulse
    output tag_t                          done_tag,
    output event_code_t [NUM_STAGES-1:0]  done_evt,
    output hold_cnt_t   [NUM_STAGES-1:0]  done_hold,
    output cycle_t                        done_cycle
);

    //////////////////////////////
    // Internal wiring
    //////////////////////////////
    logic        [NUM_STAGES-1:0] stage_valid;   // From tracker
    tag_t        [NUM_STAGES-1:0] stage_tag;     // From tracker
    tag_t                         rd_tag;        // Write-back tag to all banks
    event_code_t [NUM_STAGES-1:0] bank_evt;      // Bank read data
    hold_cnt_t   [NUM_STAGES-1:0] bank_hold;

    // Tags and valid flags through the stages
    pipeline_tag_tracker u_tracker (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .stage_valid (stage_valid),
        .stage_tag   (stage_tag)
    );

    // One record bank per stage
    for (genvar i = 0; i < NUM_STAGES; i++) begin : gen_bank
        stage_record_bank u_bank (
            .clk      (clk),
            .rst_n    (rst_n),
            .wr_valid (stage_valid[i]),
            .wr_tag   (stage_tag[i]),
            .wr_evt   (stage_evt[i]),
            .rd_tag   (rd_tag),
            .rd_evt   (bank_evt[i]),
            .rd_hold  (bank_hold[i])
        );
    end

    // Gathers the banks into one record at write-back
    retire_reporter u_reporter (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_valid   (stage_valid[STG_WB]),
        .wb_tag     (stage_tag[STG_WB]),
        .bank_evt   (bank_evt),
        .bank_hold  (bank_hold),
        .rd_tag     (rd_tag),
        .done       (done),
        .done_tag   (done_tag),
        .done_evt   (done_evt),
        .done_hold  (done_hold),
        .done_cycle (done_cycle)
    );

endmodule

//--- hdl/retire_reporter.sv
`timescale 1ns/100ps

module retire_reporter import trace_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wb_valid,    // Write-back holds an instruction
    input  tag_t                          wb_tag,      // Its tag
    input  event_code_t [NUM_STAGES-1:0]  bank_evt,    // Codes read at rd_tag
    input  hold_cnt_t   [NUM_STAGES-1:0]  bank_hold,   // Counts read at rd_tag
    output tag_t                          rd_tag,      // Shared bank read address
    output logic                          done,        // One pulse per retirement
    output tag_t                          done_tag,
    output event_code_t [NUM_STAGES-1:0]  done_evt,
    output hold_cnt_t   [NUM_STAGES-1:0]  done_hold,
    output cycle_t                        done_cycle
);

    //////////////////////////////
    // Cycle counter
    //////////////////////////////
    cycle_t cycle_cnt;                   // Number of the current cycle

    // Reads 0 in the first cycle after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + cycle_t'(1);
        end
    end

    //////////////////////////////
    // Bank lookup
    //////////////////////////////

    // Every bank is read at the retiring tag.
    // The write-back bank forwards its own write, so the
    // record includes the code of this very cycle.
    assign rd_tag = wb_tag;

    //////////////////////////////
    // Retirement record
    //////////////////////////////

    // Pulse follows each valid write-back cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= wb_valid;
        end
    end

    // Record fields only change on a retirement
    always_ff @(posedge clk) begin
        if (wb_valid) begin
            done_tag   <= wb_tag;
            done_evt   <= bank_evt;          // Fetch code in element 0
            done_hold  <= bank_hold;         // Same ordering as the codes
            done_cycle <= cycle_cnt;         // Write-back cycle, not the pulse cycle
        end
    end

endmodule

//--- hdl/stage_record_bank.sv
`timescale 1ns/100ps

module stage_record_bank import trace_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wr_valid,   // Stage holds a live instruction
    input  tag_t        wr_tag,     // Tag of that instruction
    input  event_code_t wr_evt,     // Event code of this cycle
    input  tag_t        rd_tag,     // Lookup address from the reporter
    output event_code_t rd_evt,
    output hold_cnt_t   rd_hold
);

    //////////////////////////////
    // Storage
    //////////////////////////////
    event_code_t mem_evt  [TAG_DEPTH];  // Latest code per tag
    hold_cnt_t   mem_hold [TAG_DEPTH];  // Cycles per tag in this stage

    logic      prev_valid;               // Stage was live last cycle
    tag_t      prev_tag;                 // Tag it held last cycle
    hold_cnt_t cur_hold;                 // Count stored for the tag now in the stage
    hold_cnt_t wr_hold;                  // Count to store this cycle

    // Last cycle's occupant, to tell a new arrival from a held one
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prev_valid <= 1'b0;
        end else begin
            prev_valid <= wr_valid;
        end
    end

    always_ff @(posedge clk) begin
        prev_tag <= wr_tag;              // Stage tag one cycle late
    end

    assign cur_hold = mem_hold[wr_tag];

    // New occupant restarts at 1 and a held one counts on up to the cap
    always_comb begin
        if (!prev_valid || (prev_tag != wr_tag)) begin
            wr_hold = hold_cnt_t'(1);
        end else if (cur_hold == hold_cnt_t'(HOLD_MAX)) begin
            wr_hold = cur_hold;          // Saturated
        end else begin
            wr_hold = cur_hold + hold_cnt_t'(1);
        end
    end

    // Latest write wins
    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem_evt[wr_tag]  <= wr_evt;
            mem_hold[wr_tag] <= wr_hold;
        end
    end

    //////////////////////////////
    // Read port
    //////////////////////////////

    // A write to the same tag this cycle is forwarded
    assign rd_evt  = (wr_valid && (wr_tag == rd_tag)) ? wr_evt  : mem_evt[rd_tag];
    assign rd_hold = (wr_valid && (wr_tag == rd_tag)) ? wr_hold : mem_hold[rd_tag];

endmodule

//--- hdl/pipeline_tag_tracker.sv
`timescale 1ns/100ps

module pipeline_tag_tracker import trace_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        stall,        // Holds fetch and decode
    output logic [NUM_STAGES-1:0]       stage_valid,  // Stage holds a live instruction
    output tag_t [NUM_STAGES-1:0]       stage_tag     // Tag of that instruction
);

    //////////////////////////////
    // Tag pipeline
    //////////////////////////////

    // The fetch tag register doubles as the tag counter.
    // It steps by one on every advancing fetch and wraps at TAG_DEPTH.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_tag <= '0;                                       // First fetch gets tag 0
        end else begin
            if (!stall) begin
                stage_tag[STG_FETCH]  <= stage_tag[STG_FETCH] + tag_t'(1); // Next tag
                stage_tag[STG_DECODE] <= stage_tag[STG_FETCH];     // Fetch moves on
            end

            // Execute copies decode every cycle
            // On a stall the copy is a bubble, its valid flag is low
            stage_tag[STG_EXECUTE] <= stage_tag[STG_DECODE];

            // Back half never stops
            stage_tag[STG_MEMORY] <= stage_tag[STG_EXECUTE];
            stage_tag[STG_WB]     <= stage_tag[STG_MEMORY];
        end
    end

    //////////////////////////////
    // Valid pipeline
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stage_valid <= VALID_AT_RST;                           // Fetch live, rest empty
        end else begin
            // Fetch always has an instruction in flight
            stage_valid[STG_FETCH] <= 1'b1;

            if (stall) begin
                // Decode keeps its flag, execute takes a bubble
                stage_valid[STG_EXECUTE] <= 1'b0;
            end else begin
                stage_valid[STG_DECODE]  <= stage_valid[STG_FETCH];
                stage_valid[STG_EXECUTE] <= stage_valid[STG_DECODE];
            end

            // Memory and write-back keep draining during a stall
            stage_valid[STG_MEMORY] <= stage_valid[STG_EXECUTE];
            stage_valid[STG_WB]     <= stage_valid[STG_MEMORY];
        end
    end

endmodule

//--- hdl/trace_pkg.sv
package trace_pkg;

    //////////////////////////////
    // Pipeline shape
    //////////////////////////////
    localparam int NUM_STAGES = 5;     // Fetch through write-back

    // Stage indices, also the element index in every per-stage array
    localparam int STG_FETCH   = 0;
    localparam int STG_DECODE  = 1;
    localparam int STG_EXECUTE = 2;
    localparam int STG_MEMORY  = 3;
    localparam int STG_WB      = 4;

    // Only fetch holds a live instruction right after reset
    localparam logic [NUM_STAGES-1:0] VALID_AT_RST = NUM_STAGES'(1) << STG_FETCH;

    //////////////////////////////
    // Field widths
    //////////////////////////////
    localparam int TAG_W   = 4;        // Tag wraps at 16
    localparam int EVT_W   = 8;        // Per-stage event code
    localparam int HOLD_W  = 3;        // Cycles spent in one stage
    localparam int CYCLE_W = 32;       // Cycle number since reset

    // One bank entry per possible tag
    localparam int TAG_DEPTH = 1 << TAG_W;

    // Hold count sticks here once reached
    localparam int HOLD_MAX = 7;

    //////////////////////////////
    // Types
    //////////////////////////////

    // Instruction tag, given out at fetch
    typedef logic [TAG_W-1:0] tag_t;

    // Event code a stage reports every cycle
    typedef logic [EVT_W-1:0] event_code_t;

    // Saturating count of cycles in a stage
    typedef logic [HOLD_W-1:0] hold_cnt_t;

    // Free running cycle number
    typedef logic [CYCLE_W-1:0] cycle_t;

endpackage
